// File: include/mips_id_settings.svh
// MIPS-I encodings only; REGIMM decode covers bltz and bgez, and the credit depth must fit credit_t.
`ifndef MIPS_ID_SETTINGS_SVH
`define MIPS_ID_SETTINGS_SVH

// Instruction field positions.
`define ID_OP_MSB   31
`define ID_OP_LSB   26
`define ID_RS_MSB   25
`define ID_RS_LSB   21
`define ID_RT_MSB   20
`define ID_RT_LSB   16
`define ID_IMM_MSB  15
`define ID_ADDR_MSB 25
`define ID_FN_MSB   5

// Primary opcodes.
`define OP_SPECIAL  6'h00
`define OP_REGIMM   6'h01
`define OP_J        6'h02
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_BLEZ     6'h06
`define OP_BGTZ     6'h07
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f

// SPECIAL funct codes.
`define FN_JR       6'h08
`define FN_JALR     6'h09
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

// Results that execute can hold before it must return a credit.
`define ID_CREDITS  4

`endif

// File: verilog/mips_id_pkg.sv
// Types shared by the decode stage; widths follow the 32-bit MIPS-I architecture.
package mips_id_pkg;

    typedef logic [31:0] word_t;      // Data word or byte address.
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] jaddr_t;     // Word index of a j/jal target.

    // Must hold the full credit depth.
    typedef logic [2:0]  credit_t;

    // Source of the early data output.
    typedef enum logic [1:0] {
        DO_ZERO,
        DO_LINK,
        DO_LUI,
        DO_CMP
    } do_sel_t;

    // Comparator function; the zero tests ignore the B operand.
    typedef enum logic [2:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LEZ,
        CMP_GTZ,
        CMP_LTZ,
        CMP_GEZ,
        CMP_LT
    } cmp_op_t;

    // Next-PC target form.
    typedef enum logic [1:0] {
        NPC_BRANCH,
        NPC_JUMP,
        NPC_REG
    } npc_sel_t;

endpackage

// File: verilog/id_control.sv
// Combinational decode; unsupported opcodes fall to the default controls and never jump.
`timescale 1ns/1ps
`include "mips_id_settings.svh"

module id_control import mips_id_pkg::*; (
    input  word_t    inst,
    output cmp_op_t  cmp_op,
    output logic     cmp_imm,
    output logic     cmp_signed,
    output logic     ext_signed,
    output do_sel_t  do_sel,
    output npc_sel_t npc_sel,
    output logic     is_branch
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = inst[`ID_OP_MSB:`ID_OP_LSB];
    assign funct  = inst[`ID_FN_MSB:0];

    always_comb begin
        cmp_op     = CMP_EQ;
        cmp_imm    = 1'b0;
        cmp_signed = 1'b1;
        ext_signed = 1'b1;
        do_sel     = DO_ZERO;
        npc_sel    = NPC_BRANCH;
        is_branch  = 1'b0;
        case (opcode)
            `OP_SPECIAL: begin
                case (funct)
                    `FN_JR: npc_sel = NPC_REG;
                    `FN_JALR: begin
                        npc_sel = NPC_REG;
                        do_sel  = DO_LINK;
                    end
                    `FN_SLT: begin
                        cmp_op = CMP_LT;
                        do_sel = DO_CMP;
                    end
                    `FN_SLTU: begin
                        cmp_op     = CMP_LT;
                        cmp_signed = 1'b0;
                        do_sel     = DO_CMP;
                    end
                    default: ;
                endcase
            end
            `OP_REGIMM: begin
                // The low rt bit separates bgez from bltz.
                is_branch = 1'b1;
                cmp_op    = inst[`ID_RT_LSB] ? CMP_GEZ : CMP_LTZ;
            end
            `OP_J: npc_sel = NPC_JUMP;
            `OP_JAL: begin
                npc_sel = NPC_JUMP;
                do_sel  = DO_LINK;
            end
            `OP_BEQ: is_branch = 1'b1;
            `OP_BNE: begin
                is_branch = 1'b1;
                cmp_op    = CMP_NE;
            end
            `OP_BLEZ: begin
                is_branch = 1'b1;
                cmp_op    = CMP_LEZ;
            end
            `OP_BGTZ: begin
                is_branch = 1'b1;
                cmp_op    = CMP_GTZ;
            end
            `OP_SLTI: begin
                cmp_op  = CMP_LT;
                cmp_imm = 1'b1;
                do_sel  = DO_CMP;
            end
            `OP_SLTIU: begin
                cmp_op     = CMP_LT;
                cmp_imm    = 1'b1;
                cmp_signed = 1'b0;         // Immediate is still sign-extended.
                do_sel     = DO_CMP;
            end
            `OP_ANDI, `OP_ORI, `OP_XORI: ext_signed = 1'b0;
            `OP_LUI: do_sel = DO_LUI;
            default: ;
        endcase
    end

endmodule

// File: verilog/register_file.sv
// Register zero is hardwired; a read of the register being written returns the write data.
`timescale 1ns/1ps

module register_file import mips_id_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output word_t     rs_val,
    output word_t     rt_val
);

    word_t regs [1:31];
    logic  wr_en;

    assign wr_en = wb_en && (wb_addr != 5'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Decode reads the value that writeback commits at this same edge.
    always_comb begin
        if (rs_addr == 5'd0)
            rs_val = '0;
        else if (wr_en && (wb_addr == rs_addr))
            rs_val = wb_data;
        else
            rs_val = regs[rs_addr];
        if (rt_addr == 5'd0)
            rt_val = '0;
        else if (wr_en && (wb_addr == rt_addr))
            rt_val = wb_data;
        else
            rt_val = regs[rt_addr];
    end

endmodule

// File: verilog/branch_unit.sv
// Branches resolve in decode without forwarding, so operands must already be in the register file.
`timescale 1ns/1ps

module branch_unit import mips_id_pkg::*; (
    input  word_t    rs_val,
    input  word_t    rt_val,
    input  word_t    imm_ext,
    input  word_t    pc4,
    input  jaddr_t   jaddr,
    input  cmp_op_t  cmp_op,
    input  logic     cmp_imm,
    input  logic     cmp_signed,
    input  npc_sel_t npc_sel,
    input  logic     is_branch,
    output logic     cmp_true,
    output logic     jump,
    output word_t    target
);

    word_t cmp_b;
    logic  rs_zero;
    logic  rs_neg;
    logic  lt_signed;
    logic  lt_unsigned;

    assign cmp_b       = cmp_imm ? imm_ext : rt_val;
    assign rs_zero     = (rs_val == '0);
    assign rs_neg      = rs_val[31];
    assign lt_signed   = $signed(rs_val) < $signed(cmp_b);
    assign lt_unsigned = rs_val < cmp_b;

    always_comb begin
        case (cmp_op)
            CMP_EQ:  cmp_true = (rs_val == cmp_b);
            CMP_NE:  cmp_true = (rs_val != cmp_b);
            CMP_LEZ: cmp_true = rs_neg | rs_zero;
            CMP_GTZ: cmp_true = !rs_neg && !rs_zero;
            CMP_LTZ: cmp_true = rs_neg;
            CMP_GEZ: cmp_true = !rs_neg;
            CMP_LT:  cmp_true = cmp_signed ? lt_signed : lt_unsigned;
            default: cmp_true = 1'b0;
        endcase
    end

    // Jumps are unconditional; only conditional branches consult the comparator.
    assign jump = is_branch ? cmp_true : (npc_sel != NPC_BRANCH);

    always_comb begin
        case (npc_sel)
            NPC_JUMP: target = {pc4[31:28], jaddr, 2'b00};
            NPC_REG:  target = rs_val;
            default:  target = pc4 + {imm_ext[29:0], 2'b00};   // Word offset from the delay slot.
        endcase
    end

endmodule

// File: verilog/operand_unit.sv
// The link address skips the delay slot; DO is zero for anything without an early result.
`timescale 1ns/1ps

module operand_unit import mips_id_pkg::*; (
    input  imm16_t  imm,
    input  logic    ext_signed,
    input  word_t   pc4,
    input  logic    cmp_true,
    input  do_sel_t do_sel,
    output word_t   imm_ext,
    output word_t   do_val
);

    word_t link_addr;
    word_t lui_val;
    word_t cmp_word;

    assign imm_ext = ext_signed ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    assign link_addr = pc4 + 32'd4;
    assign lui_val   = {imm, 16'h0000};
    assign cmp_word  = {31'd0, cmp_true};   // Set-less-than writes 0 or 1.

    always_comb begin
        case (do_sel)
            DO_LINK: do_val = link_addr;
            DO_LUI:  do_val = lui_val;
            DO_CMP:  do_val = cmp_word;
            default: do_val = '0;
        endcase
    end

endmodule

// File: verilog/id_stage.sv
// Execute must return exactly one credit per result; a credit pulse with no result outstanding is ignored.
`timescale 1ns/1ps
`include "mips_id_settings.svh"

module id_stage import mips_id_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  in_valid,
    input  word_t in_inst,
    input  word_t rs_val,
    input  word_t rt_val,
    input  word_t imm_ext,
    input  word_t do_val,
    input  logic  jump,
    input  word_t target,
    input  logic  credit_return,
    output logic  in_ready,
    output logic  out_valid,
    output word_t out_inst,
    output word_t out_rs_val,
    output word_t out_rt_val,
    output word_t out_imm,
    output word_t out_do,
    output logic  out_jump,
    output word_t out_target
);

    credit_t credits;
    logic    accept;
    logic    credit_inc;

    assign in_ready   = (credits != '0);
    assign accept     = in_valid && in_ready;
    assign credit_inc = credit_return && (credits != credit_t'(`ID_CREDITS));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= credit_t'(`ID_CREDITS);
        end else begin
            case ({accept, credit_inc})
                2'b10:   credits <= credits - 3'd1;
                2'b01:   credits <= credits + 3'd1;
                default: credits <= credits;   // Idle, or a result and a credit cancel out.
            endcase
        end
    end

    // A free credit means execute has room, so the register never has to hold a result.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_inst   <= in_inst;
            out_rs_val <= rs_val;
            out_rt_val <= rt_val;
            out_imm    <= imm_ext;
            out_do     <= do_val;
            out_jump   <= jump;
            out_target <= target;
        end
    end

endmodule

// File: verilog/mips_id_top.sv
// Decode stage top; there is no hazard detection, so writeback data must be ready at decode time.
`timescale 1ns/1ps
`include "mips_id_settings.svh"

module mips_id_top import mips_id_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      in_valid,
    input  word_t     in_inst,
    input  word_t     in_pc4,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    input  logic      credit_return,
    output logic      in_ready,
    output logic      out_valid,
    output word_t     out_inst,
    output word_t     out_rs_val,
    output word_t     out_rt_val,
    output word_t     out_imm,
    output word_t     out_do,
    output logic      out_jump,
    output word_t     out_target
);

    cmp_op_t  cmp_op;
    logic     cmp_imm;
    logic     cmp_signed;
    logic     ext_signed;
    do_sel_t  do_sel;
    npc_sel_t npc_sel;
    logic     is_branch;
    word_t    rs_val;
    word_t    rt_val;
    word_t    imm_ext;
    word_t    do_val;
    logic     cmp_true;
    logic     jump;
    word_t    target;

    id_control id_control_i (
        .inst(in_inst), .cmp_op(cmp_op), .cmp_imm(cmp_imm), .cmp_signed(cmp_signed),
        .ext_signed(ext_signed), .do_sel(do_sel), .npc_sel(npc_sel), .is_branch(is_branch)
    );

    register_file register_file_i (
        .clk(clk), .arst_n(arst_n),
        .rs_addr(in_inst[`ID_RS_MSB:`ID_RS_LSB]), .rt_addr(in_inst[`ID_RT_MSB:`ID_RT_LSB]),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .rs_val(rs_val), .rt_val(rt_val)
    );

    branch_unit branch_unit_i (
        .rs_val(rs_val), .rt_val(rt_val), .imm_ext(imm_ext), .pc4(in_pc4),
        .jaddr(in_inst[`ID_ADDR_MSB:0]), .cmp_op(cmp_op), .cmp_imm(cmp_imm),
        .cmp_signed(cmp_signed), .npc_sel(npc_sel), .is_branch(is_branch),
        .cmp_true(cmp_true), .jump(jump), .target(target)
    );

    operand_unit operand_unit_i (
        .imm(in_inst[`ID_IMM_MSB:0]), .ext_signed(ext_signed), .pc4(in_pc4),
        .cmp_true(cmp_true), .do_sel(do_sel), .imm_ext(imm_ext), .do_val(do_val)
    );

    id_stage id_stage_i (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_inst(in_inst),
        .rs_val(rs_val), .rt_val(rt_val), .imm_ext(imm_ext), .do_val(do_val),
        .jump(jump), .target(target), .credit_return(credit_return), .in_ready(in_ready),
        .out_valid(out_valid), .out_inst(out_inst), .out_rs_val(out_rs_val),
        .out_rt_val(out_rt_val), .out_imm(out_imm), .out_do(out_do),
        .out_jump(out_jump), .out_target(out_target)
    );

endmodule

// File: sim/mips_id_tb.sv
// Inputs wait for credit; a result frees one 0 to 5 cycles later; stray pulses only at full credit.
`timescale 1ns/1ps
`include "mips_id_settings.svh"

module mips_id_tb;

    localparam int NUM_TESTS  = 3000;
    localparam int MAX_CYCLES = 20 * NUM_TESTS;
    localparam logic [5:0] OP_ADDIU = 6'h09;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] imm;
        logic [31:0] dov;
        logic        jump;
        logic [31:0] target;
    } result_t;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic [31:0] in_inst;
    logic [31:0] in_pc4;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        credit_return;
    logic        in_ready;
    logic        out_valid;
    logic [31:0] out_inst;
    logic [31:0] out_rs_val;
    logic [31:0] out_rt_val;
    logic [31:0] out_imm;
    logic [31:0] out_do;
    logic        out_jump;
    logic [31:0] out_target;

    logic [31:0] mirror [0:31];
    result_t     exp_q [$];
    int unsigned hold_q [$];   // Cycle at which each received result returns its credit.
    int          model_credits;
    int          errors;
    int          accepted;
    int unsigned cycle;
    logic        held;         // The offered transfer is still waiting for a credit.

    mips_id_top mips_id_top_i (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_inst(in_inst),
        .in_pc4(in_pc4), .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .credit_return(credit_return), .in_ready(in_ready), .out_valid(out_valid),
        .out_inst(out_inst), .out_rs_val(out_rs_val), .out_rt_val(out_rt_val),
        .out_imm(out_imm), .out_do(out_do), .out_jump(out_jump), .out_target(out_target)
    );

    always #50 clk = ~clk;

    // Half the picks land in the low eight registers so writes and reads collide often.
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $urandom;
        return r[31] ? {2'b00, r[2:0]} : r[4:0];
    endfunction

    function automatic logic [31:0] pick_data();
        logic [31:0] r;
        r = $urandom;
        case (r[1:0])
            2'd0:    return 32'd0;
            2'd1:    return {{29{r[31]}}, r[4:2]};   // Small values of either sign.
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] inst;
        logic [4:0]  rs;
        logic [4:0]  rt;
        int unsigned kind;
        inst = $urandom;
        rs = pick_reg();
        rt = ($urandom % 4 == 0) ? rs : pick_reg();
        inst[25:21] = rs;
        inst[20:16] = rt;
        kind = $urandom % 17;
        case (kind)
            0, 1, 2, 3: begin
                inst[31:26] = `OP_SPECIAL;
                case (kind)
                    0:       inst[5:0] = `FN_JR;
                    1:       inst[5:0] = `FN_JALR;
                    2:       inst[5:0] = `FN_SLT;
                    default: inst[5:0] = `FN_SLTU;
                endcase
            end
            4: begin
                inst[31:26] = `OP_REGIMM;
                inst[20:16] = {4'd0, rt[0]};
            end
            5:  inst[31:26] = `OP_J;
            6:  inst[31:26] = `OP_JAL;
            7:  inst[31:26] = `OP_BEQ;
            8:  inst[31:26] = `OP_BNE;
            9:  inst[31:26] = `OP_BLEZ;
            10: inst[31:26] = `OP_BGTZ;
            11: inst[31:26] = `OP_SLTI;
            12: inst[31:26] = `OP_SLTIU;
            13: inst[31:26] = `OP_LUI;
            14: inst[31:26] = `OP_ANDI;
            15: inst[31:26] = `OP_ORI;
            default: inst[31:26] = OP_ADDIU;
        endcase
        return inst;
    endfunction

    // A read in the cycle of a write to the same register sees the new data.
    function automatic logic [31:0] read_mirror(input logic [4:0] addr);
        if (addr == 5'd0)
            return 32'd0;
        if (wb_en && (wb_addr == addr))
            return wb_data;
        return mirror[addr];
    endfunction

    function automatic result_t predict(input logic [31:0] inst, input logic [31:0] pc4,
                                        input logic [31:0] rs_v, input logic [31:0] rt_v);
        result_t     r;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [15:0] imm;
        logic [31:0] sext;
        op = inst[31:26];
        fn = inst[5:0];
        imm = inst[15:0];
        sext = {{16{imm[15]}}, imm};
        r.inst = inst;
        r.rs_val = rs_v;
        r.rt_val = rt_v;
        if (op == `OP_ANDI || op == `OP_ORI || op == `OP_XORI)
            r.imm = {16'h0000, imm};
        else
            r.imm = sext;
        r.dov = 32'd0;
        r.jump = 1'b0;
        r.target = pc4 + (r.imm << 2);
        case (op)
            `OP_SPECIAL: begin
                if (fn == `FN_JR || fn == `FN_JALR) begin
                    r.jump = 1'b1;
                    r.target = rs_v;
                end
                if (fn == `FN_JALR)
                    r.dov = pc4 + 32'd4;
                if (fn == `FN_SLT)
                    r.dov = {31'd0, $signed(rs_v) < $signed(rt_v)};
                if (fn == `FN_SLTU)
                    r.dov = {31'd0, rs_v < rt_v};
            end
            `OP_REGIMM: r.jump = inst[16] ? !rs_v[31] : rs_v[31];
            `OP_J, `OP_JAL: begin
                r.jump = 1'b1;
                r.target = {pc4[31:28], inst[25:0], 2'b00};
                if (op == `OP_JAL)
                    r.dov = pc4 + 32'd4;
            end
            `OP_BEQ:   r.jump = (rs_v == rt_v);
            `OP_BNE:   r.jump = (rs_v != rt_v);
            `OP_BLEZ:  r.jump = ($signed(rs_v) <= 32'sd0);
            `OP_BGTZ:  r.jump = ($signed(rs_v) > 32'sd0);
            `OP_SLTI:  r.dov = {31'd0, $signed(rs_v) < $signed(sext)};
            `OP_SLTIU: r.dov = {31'd0, rs_v < sext};
            `OP_LUI:   r.dov = {imm, 16'h0000};
            default: ;
        endcase
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_output();
        result_t e;
        if (out_valid) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Error: an output appeared at %0t with no pending input", $time);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_field("out_inst", out_inst, e.inst);
                check_field("out_rs_val", out_rs_val, e.rs_val);
                check_field("out_rt_val", out_rt_val, e.rt_val);
                check_field("out_imm", out_imm, e.imm);
                check_field("out_do", out_do, e.dov);
                check_field("out_jump", {31'd0, out_jump}, {31'd0, e.jump});
                check_field("out_target", out_target, e.target);
            end
            hold_q.push_back(cycle + ($urandom % 6));
        end else begin
            assert (exp_q.size() == 0) else begin
                errors++;
                $display("Error: an accepted input produced no output by %0t", $time);
                void'(exp_q.pop_front());
            end
        end
    endtask

    task automatic drive_cycle();
        logic        model_ready;
        logic        credit_inc;
        logic [31:0] r;
        credit_return = 1'b0;
        if (hold_q.size() != 0 && hold_q[0] <= cycle) begin
            credit_return = 1'b1;
            void'(hold_q.pop_front());
        end else if (model_credits == `ID_CREDITS) begin
            credit_return = ($urandom % 8 == 0);   // The full counter must ignore this pulse.
        end
        r = $urandom;
        wb_en = r[0];
        wb_addr = pick_reg();
        wb_data = pick_data();
        // A stalled transfer keeps its data until the stage takes it.
        if (!held) begin
            in_valid = (accepted < NUM_TESTS) && (r[3:2] != 2'b00);
            in_inst = random_inst();
            r = $urandom;
            in_pc4 = {r[31:2], 2'b00};
        end
        model_ready = (model_credits != 0);
        assert (in_ready === model_ready) else begin
            errors++;
            if (!model_ready && in_valid)
                $display("Error: input was offered and accepted at %0t with no credits", $time);
            else
                $display("Fail %0t: in_ready got %b expected %b", $time, in_ready, model_ready);
        end
        credit_inc = credit_return && (model_credits != `ID_CREDITS);
        if (in_valid && model_ready) begin
            exp_q.push_back(predict(in_inst, in_pc4, read_mirror(in_inst[25:21]),
                                    read_mirror(in_inst[20:16])));
            accepted++;
            model_credits--;
        end
        if (credit_inc)
            model_credits++;
        held = in_valid && !model_ready;
        if (wb_en && wb_addr != 5'd0)
            mirror[wb_addr] = wb_data;
        assert (hold_q.size() + ((in_valid && in_ready) ? 1 : 0) <= `ID_CREDITS) else begin
            errors++;
            $display("Error: more results are outstanding than there are credits at %0t", $time);
        end
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_inst = 32'd0;
        in_pc4 = 32'd0;
        wb_en = 1'b0;
        wb_addr = 5'd0;
        wb_data = 32'd0;
        credit_return = 1'b0;
        errors = 0;
        accepted = 0;
        cycle = 0;
        held = 1'b0;
        model_credits = `ID_CREDITS;
        for (int i = 0; i < 32; i++) begin
            mirror[i] = 32'd0;
        end
        void'($urandom(32'ha1b6b49a));
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        check_field("in_ready after reset", {31'd0, in_ready}, 32'd1);
        check_field("out_valid after reset", {31'd0, out_valid}, 32'd0);
        while ((accepted < NUM_TESTS || exp_q.size() != 0) && cycle < MAX_CYCLES) begin
            @(negedge clk);
            cycle++;
            check_output();
            drive_cycle();
        end
        if (cycle >= MAX_CYCLES) begin
            errors++;
            $display("Timeout: the run stopped after %0d cycles with %0d of %0d accepted",
                     cycle, accepted, NUM_TESTS);
        end
        $display("errors: %0d, accepted: %0d, cycles: %0d", errors, accepted, cycle);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: mips_id.f
+incdir+include
verilog/mips_id_pkg.sv
verilog/id_control.sv
verilog/register_file.sv
verilog/branch_unit.sv
verilog/operand_unit.sv
verilog/id_stage.sv
verilog/mips_id_top.sv
sim/mips_id_tb.sv

// File: Makefile
# Verilator simulation of the MIPS decode stage.
VERILATOR ?= verilator
TOP       ?= mips_id_tb
FILELIST  ?= mips_id.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
